//--- all.f
rtl/vread_pkg.sv
rtl/output_addr_gen.sv
rtl/pingpong_ram.sv
rtl/databus_arbiter.sv
rtl/vread_lane.sv
rtl/lane_gather.sv
rtl/vread_top.sv
verif/vread_asserts.sv
verif/tb_vread.sv

//--- verif/tb_vread.sv
`timescale 1ns/1ns

module tb_vread;
   import vread_pkg::*;

   localparam int MEM_WORDS = 1024;
   localparam int HALF_W    = BUF_ADDR_W - 1;

   logic        clk;
   logic        rst;
   logic        run_i;
   lane_cfg_t   cfg [LANES];
   db_req_t     db_req;
   db_rsp_t     db_rsp;
   gather_out_t dut_out;
   logic        done;

   integer                seed;
   string                 test_name;
   int                    ready_pct;
   int                    check_cnt;
   int                    mismatch_cnt;
   int                    fail_cnt;
   logic [DATA_W-1:0]     ext_mem [MEM_WORDS];
   // reference copy of both halves of every lane buffer
   logic [DATA_W-1:0]     shadow [LANES][2**BUF_ADDR_W];
   logic                  pp_ref [LANES];
   logic [BUF_ADDR_W-1:0] exp_addr_q [LANES][$];
   int                    out_seen [LANES];
   int                    run_age;
   int                    beat_cnt;
   int                    cur_lane;
   logic [EXT_ADDR_W-1:0] burst_addr;
   int                    bursts_done;
   int                    bursts_exp;

   vread_top dut0 (
      .clk      (clk),
      .rst      (rst),
      .run_i    (run_i),
      .cfg_i    (cfg),
      .db_req_o (db_req),
      .db_rsp_i (db_rsp),
      .out_o    (dut_out),
      .done_o   (done)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // cycles since the rising edge that sampled run_i
   always @(posedge clk) begin
      if (run_i) begin
         run_age = 0;
      end else begin
         run_age++;
      end
   end

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      mismatch_cnt++;
      $display("ERROR test %s, %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
   endtask

   task automatic report_failure(input string msg);
      fail_cnt++;
      $display("error in test %s: %s", test_name, msg);
   endtask

   function automatic lane_cfg_t make_cfg(input int lane, input logic en, input logic pp,
         input int len, input int start, input int per, input int incr, input int iter,
         input int shift, input int delay);
      lane_cfg_t c;
      c.enabled   = en;
      c.ping_pong = pp;
      // each lane owns its own 256 word region of external memory
      c.ext_addr  = EXT_ADDR_W'(lane * 1024 + ($random(seed) & 32'h1fc));
      c.len       = LEN_W'(len);
      c.start     = HALF_W'(start);
      c.per       = PERIOD_W'(per);
      c.incr      = HALF_W'(incr);
      c.iter      = HALF_W'(iter);
      c.shift     = HALF_W'(shift);
      c.delay     = DELAY_W'(delay);
      return c;
   endfunction

   function automatic int find_lane(input logic [EXT_ADDR_W-1:0] addr);
      int lane;
      lane = -1;
      for (int i = 0; i < LANES; i++) begin
         if (cfg[i].enabled && cfg[i].ext_addr == addr) lane = i;
      end
      return lane;
   endfunction

   task automatic check_outputs();
      logic [BUF_ADDR_W-1:0] a;
      logic [DATA_W-1:0]     exp;
      int                    exp_cyc;
      for (int i = 0; i < LANES; i++) begin
         if (dut_out.valid[i]) begin
            if (exp_addr_q[i].size() == 0) begin
               report_failure($sformatf("lane %0d gave an output that was not expected", i));
            end else begin
               a   = exp_addr_q[i].pop_front();
               exp = shadow[i][a];
               check_cnt++;
               assert (dut_out.data[i] == exp)
                  else report_mismatch($sformatf("lane %0d word %0h", i, a), exp,
                                       dut_out.data[i]);
               // first address delay+1 cycles after run, then one per cycle, out_o two later
               exp_cyc = int'(cfg[i].delay) + 2 + out_seen[i];
               assert (run_age == exp_cyc)
                  else report_mismatch($sformatf("lane %0d output cycle", i), exp_cyc,
                                       run_age);
               out_seen[i]++;
            end
         end
      end
   endtask

   // external memory model serves one beat per cycle with random ready
   task automatic serve_databus();
      int word;
      if (db_rsp.ready) begin
         if (cur_lane >= 0) begin
            shadow[cur_lane][{pp_ref[cur_lane], beat_cnt[HALF_W-1:0]}] = db_rsp.rdata;
         end
         if (db_rsp.last) begin
            beat_cnt = 0;
            bursts_done++;
         end else begin
            beat_cnt++;
         end
      end
      db_rsp = '0;
      if (db_req.valid) begin
         if (beat_cnt != 0 && db_req.addr != burst_addr) begin
            report_failure("a burst was interrupted by another request");
         end
         burst_addr = db_req.addr;
         cur_lane   = find_lane(db_req.addr);
         if (cur_lane < 0) begin
            report_failure("request from a disabled or unknown lane");
         end else begin
            assert (db_req.len == cfg[cur_lane].len)
               else report_mismatch("request length", cfg[cur_lane].len, db_req.len);
         end
         word         = (int'(db_req.addr >> 2) + beat_cnt) % MEM_WORDS;
         db_rsp.ready = (($random(seed) & 32'h7fff_ffff) % 100) < ready_pct;
         db_rsp.rdata = ext_mem[word];
         db_rsp.last  = (beat_cnt == int'(db_req.len));
      end
   endtask

   always @(negedge clk) begin
      if (!rst) begin
         check_outputs();
         serve_databus();
      end
   end

   task automatic check_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_cnt++;
         assert (done === 1'b1) else report_mismatch("done_o", 1, done);
         assert (db_req.valid === 1'b0) else report_mismatch("request valid", 0, db_req.valid);
         assert (dut_out.valid === '0) else report_mismatch("output valid", 0, dut_out.valid);
      end
   endtask

   task automatic run_and_wait(input string name, input int limit);
      int sum;
      int n;
      test_name   = name;
      bursts_done = 0;
      bursts_exp  = 0;
      for (int i = 0; i < LANES; i++) begin
         // fill half flips with ping_pong and the read half is the other one
         pp_ref[i]   = cfg[i].ping_pong ? !pp_ref[i] : 1'b0;
         out_seen[i] = 0;
         if (cfg[i].enabled) bursts_exp++;
         for (int j = 0; j < int'(cfg[i].iter); j++) begin
            for (int k = 0; k < int'(cfg[i].per); k++) begin
               sum = int'(cfg[i].start) + j * int'(cfg[i].shift) + k * int'(cfg[i].incr);
               exp_addr_q[i].push_back({cfg[i].ping_pong && !pp_ref[i], sum[HALF_W-1:0]});
            end
         end
      end
      run_i = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      n     = 0;
      while (done !== 1'b1 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (done !== 1'b1) begin
         report_failure("done_o did not rise before the timeout");
      end else begin
         check_cnt++;
         assert (bursts_done == bursts_exp)
            else report_mismatch("bursts finished at done", bursts_exp, bursts_done);
         for (int i = 0; i < LANES; i++) begin
            assert (exp_addr_q[i].size() == 0)
               else report_mismatch($sformatf("lane %0d outputs missing", i), 0,
                                    exp_addr_q[i].size());
         end
      end
   endtask

   initial begin
      seed         = 32'h7ca3_0d9c;
      rst          = 1'b1;
      run_i        = 1'b0;
      db_rsp       = '0;
      ready_pct    = 70;
      check_cnt    = 0;
      mismatch_cnt = 0;
      fail_cnt     = 0;
      beat_cnt     = 0;
      cur_lane     = -1;
      burst_addr   = '0;
      run_age      = 0;
      for (int i = 0; i < LANES; i++) begin
         cfg[i]      = '0;
         pp_ref[i]   = 1'b0;
         out_seen[i] = 0;
      end
      for (int a = 0; a < MEM_WORDS; a++) ext_mem[a] = $random(seed);
      repeat (16) @(negedge clk);
      rst       = 1'b0;
      test_name = "reset";
      check_idle(8);

      // fill half 1 completely and read it back while half 0 fills
      for (int i = 0; i < LANES; i++) cfg[i] = make_cfg(i, 1, 1, 127, 0, 0, 0, 0, 0, 0);
      run_and_wait("pingpong_fill", 3000);
      for (int i = 0; i < LANES; i++) cfg[i] = make_cfg(i, 1, 1, 127, i * 9, 8, 1, 2, 16, 0);
      run_and_wait("pingpong_a", 3000);
      for (int i = 0; i < LANES; i++) cfg[i] = make_cfg(i, 1, 1, 15, 3 + i, 5, 3, 3, 7, 2);
      run_and_wait("pingpong_b", 1000);

      // reads start after every short burst has landed
      ready_pct = 100;
      for (int i = 0; i < LANES; i++) cfg[i] = make_cfg(i, 1, 0, 1, 0, 4, 1, 1, 0, 15);
      run_and_wait("no_pingpong", 500);

      ready_pct = 70;
      for (int i = 0; i < LANES; i++) begin
         cfg[i] = make_cfg(i, 1, 1, 7, 120 - 7 * i, 3 + i, 1 + 2 * i, 2 + i, 20 + 13 * i, 3 * i);
      end
      run_and_wait("two_level", 1000);

      ready_pct = 40;
      for (int i = 0; i < LANES; i++) cfg[i] = make_cfg(i, 1, 1, 31, 0, 32, 1, 1, 0, 0);
      run_and_wait("arb_backpressure", 2000);

      // lane 2 keeps streaming what the previous run loaded
      ready_pct = 70;
      for (int i = 0; i < LANES; i++) cfg[i] = make_cfg(i, i != 2, 1, 15, 5, 6, 2, 2, 11, 1);
      run_and_wait("disabled_lane", 1000);

      $display("checks %0d, data mismatches %0d, other errors %0d, assertion failures %0d",
               check_cnt, mismatch_cnt, fail_cnt, dut0.u_vread_asserts.assert_errs);
      if (mismatch_cnt + fail_cnt + dut0.u_vread_asserts.assert_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- verif/vread_asserts.sv
`timescale 1ns/1ns

module vread_asserts (
   input logic                   clk,
   input logic                   rst,
   input logic                   run_i,
   input vread_pkg::db_req_t     db_req_i,
   input vread_pkg::db_rsp_t     db_rsp_i,
   input vread_pkg::gather_out_t out_i,
   input logic                   done_i
);

   int   assert_errs = 0;
   logic end_beat;

   assign end_beat = db_rsp_i.ready && db_rsp_i.last;

   // request held from its first cycle until the last beat
   req_stable: assert property (@(posedge clk) disable iff (rst)
      (db_req_i.valid && !end_beat) |=> (db_req_i.valid && $stable(db_req_i)))
   else begin
      assert_errs++;
      $error("databus request changed before its last beat");
   end

   beat_needs_req: assert property (@(posedge clk) disable iff (rst)
      db_rsp_i.ready |-> db_req_i.valid)
   else begin
      assert_errs++;
      $error("databus beat without a valid request");
   end

   done_low_after_run: assert property (@(posedge clk) disable iff (rst)
      run_i |=> !done_i)
   else begin
      assert_errs++;
      $error("done_o still high in the cycle after run_i");
   end

   // outputs only while a run is in progress
   no_valid_when_done: assert property (@(posedge clk) disable iff (rst)
      (|out_i.valid) |-> !done_i)
   else begin
      assert_errs++;
      $error("output valid while done_o is high");
   end

endmodule

bind vread_top vread_asserts u_vread_asserts (
   .clk      (clk),
   .rst      (rst),
   .run_i    (run_i),
   .db_req_i (db_req_o),
   .db_rsp_i (db_rsp_i),
   .out_i    (out_o),
   .done_i   (done_o)
);

//--- rtl/vread_top.sv
`timescale 1ns/1ns

module vread_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  vread_pkg::lane_cfg_t   cfg_i [vread_pkg::LANES],
   output vread_pkg::db_req_t     db_req_o,
   input  vread_pkg::db_rsp_t     db_rsp_i,
   output vread_pkg::gather_out_t out_o,
   output logic                   done_o
);
   import vread_pkg::*;

   db_req_t          lane_req  [LANES];
   db_rsp_t          lane_rsp  [LANES];
   lane_out_t        lane_out  [LANES];
   logic [LANES-1:0] lane_done;

   // one external databus shared by all lanes
   databus_arbiter u_arbiter (
      .clk        (clk),
      .rst        (rst),
      .lane_req_i (lane_req),
      .lane_rsp_o (lane_rsp),
      .ext_req_o  (db_req_o),
      .ext_rsp_i  (db_rsp_i)
   );

   for (genvar g = 0; g < LANES; g++) begin : g_lane
      vread_lane u_lane (
         .clk    (clk),
         .rst    (rst),
         .run_i  (run_i),
         .cfg_i  (cfg_i[g]),
         .req_o  (lane_req[g]),
         .rsp_i  (lane_rsp[g]),
         .out_o  (lane_out[g]),
         .done_o (lane_done[g])
      );
   end

   lane_gather u_gather (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .lane_out_i  (lane_out),
      .lane_done_i (lane_done),
      .out_o       (out_o),
      .done_o      (done_o)
   );

endmodule

//--- rtl/lane_gather.sv
`timescale 1ns/1ns

module lane_gather (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  vread_pkg::lane_out_t   lane_out_i [vread_pkg::LANES],
   input  logic [vread_pkg::LANES-1:0] lane_done_i,
   output vread_pkg::gather_out_t out_o,
   output logic                   done_o
);
   import vread_pkg::*;

   logic [LANES-1:0]             lane_valid;
   logic [LANES-1:0]             valid_q;
   logic [LANES-1:0][DATA_W-1:0] data_q;
   logic                         done_q;

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         lane_valid[i] = lane_out_i[i].valid;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q <= '0;
      end else begin
         valid_q <= lane_valid;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < LANES; i++) begin
         if (lane_valid[i]) data_q[i] <= lane_out_i[i].data;
      end
   end

   // sticky done, waits until the last lane word has left the lanes
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q <= 1'b1;
      end else if (run_i) begin
         done_q <= 1'b0;
      end else if ((&lane_done_i) && !(|lane_valid)) begin
         done_q <= 1'b1;
      end
   end

   assign out_o.valid = valid_q;
   assign out_o.data  = data_q;
   assign done_o      = done_q;

endmodule

//--- rtl/vread_lane.sv
`timescale 1ns/1ns

module vread_lane (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run_i,
   input  vread_pkg::lane_cfg_t cfg_i,
   output vread_pkg::db_req_t   req_o,
   input  vread_pkg::db_rsp_t   rsp_i,
   output vread_pkg::lane_out_t out_o,
   output logic                 done_o
);
   import vread_pkg::*;

   lane_cfg_t             cfg_q;
   lane_cfg_t             cfg_cur;
   logic                  pp_state;
   logic                  read_half;
   logic                  req_valid;
   logic                  burst_done;
   logic                  beat;
   logic [BUF_ADDR_W-2:0] wr_cnt;
   logic                  gen_valid;
   logic [BUF_ADDR_W-2:0] gen_addr;
   logic                  gen_done;
   logic                  out_valid;
   logic [DATA_W-1:0]     ram_rdata;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg_q <= '0;
      end else if (run_i) begin
         cfg_q <= cfg_i;
      end
   end

   // generator loads its start values in the run cycle itself
   assign cfg_cur = run_i ? cfg_i : cfg_q;

   // pp_state is the half being filled
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run_i) begin
         pp_state <= cfg_i.ping_pong ? !pp_state : 1'b0;
      end
   end

   assign read_half = cfg_q.ping_pong && !pp_state;

   // burst fill
   assign beat = req_valid && rsp_i.ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         req_valid  <= 1'b0;
         burst_done <= 1'b1;
         wr_cnt     <= '0;
      end else if (run_i) begin
         req_valid  <= cfg_i.enabled;
         burst_done <= !cfg_i.enabled;
         wr_cnt     <= '0;
      end else if (beat) begin
         wr_cnt <= wr_cnt + 1'b1;
         if (rsp_i.last) begin
            req_valid  <= 1'b0;
            burst_done <= 1'b1;
         end
      end
   end

   assign req_o = '{valid: req_valid, addr: cfg_q.ext_addr, len: cfg_q.len};

   output_addr_gen u_addr_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .start_i (cfg_cur.start),
      .incr_i  (cfg_cur.incr),
      .shift_i (cfg_cur.shift),
      .iter_i  (cfg_cur.iter),
      .per_i   (cfg_cur.per),
      .delay_i (cfg_cur.delay),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  (gen_done)
   );

   pingpong_ram u_ram (
      .clk     (clk),
      .we_i    (beat),
      .waddr_i ({pp_state, wr_cnt}),
      .wdata_i (rsp_i.rdata),
      .re_i    (gen_valid),
      .raddr_i ({read_half, gen_addr}),
      .rdata_o (ram_rdata)
   );

   // matches the registered RAM read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= gen_valid;
      end
   end

   assign out_o  = '{valid: out_valid, data: ram_rdata};
   assign done_o = burst_done && gen_done;

endmodule

//--- rtl/databus_arbiter.sv
`timescale 1ns/1ns

module databus_arbiter (
   input  logic              clk,
   input  logic              rst,
   input  vread_pkg::db_req_t lane_req_i [vread_pkg::LANES],
   output vread_pkg::db_rsp_t lane_rsp_o [vread_pkg::LANES],
   output vread_pkg::db_req_t ext_req_o,
   input  vread_pkg::db_rsp_t ext_rsp_i
);
   import vread_pkg::*;

   localparam int GNT_W = (LANES > 1) ? $clog2(LANES) : 1;

   logic [GNT_W-1:0] grant_ptr;
   logic [GNT_W-1:0] pick;
   logic [GNT_W-1:0] sel;
   logic             busy;
   logic             found;
   logic             active;
   logic             end_beat;

   // round robin search, starting after the last granted lane
   always_comb begin
      int idx;
      pick  = grant_ptr;
      found = 1'b0;
      for (int i = 1; i <= LANES; i++) begin
         idx = (int'(grant_ptr) + i) % LANES;
         if (!found && lane_req_i[idx].valid) begin
            pick  = GNT_W'(idx);
            found = 1'b1;
         end
      end
   end

   // grant is locked while a burst is running
   assign sel      = busy ? grant_ptr : pick;
   assign active   = busy || found;
   assign end_beat = ext_rsp_i.ready && ext_rsp_i.last;

   assign ext_req_o = active ? lane_req_i[sel] : '0;

   // only the granted lane sees the response
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         if (active && (sel == GNT_W'(i))) begin
            lane_rsp_o[i] = ext_rsp_i;
         end else begin
            lane_rsp_o[i] = '0;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         grant_ptr <= GNT_W'(LANES - 1);
         busy      <= 1'b0;
      end else if (!busy) begin
         if (found) begin
            grant_ptr <= pick;
            // a single beat burst can finish in its first cycle
            busy      <= !end_beat;
         end
      end else if (end_beat) begin
         busy <= 1'b0;
      end
   end

endmodule

//--- rtl/pingpong_ram.sv
`timescale 1ns/1ns

module pingpong_ram (
   input  logic                           clk,
   input  logic                           we_i,
   input  logic [vread_pkg::BUF_ADDR_W-1:0] waddr_i,
   input  logic [vread_pkg::DATA_W-1:0]     wdata_i,
   input  logic                           re_i,
   input  logic [vread_pkg::BUF_ADDR_W-1:0] raddr_i,
   output logic [vread_pkg::DATA_W-1:0]     rdata_o
);
   import vread_pkg::*;

   // both halves in one array
   localparam int DEPTH = 2 ** BUF_ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // read port, old data on a same address collision
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

//--- rtl/output_addr_gen.sv
`timescale 1ns/1ns

module output_addr_gen (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run_i,
   input  logic [vread_pkg::BUF_ADDR_W-2:0] start_i,
   input  logic [vread_pkg::BUF_ADDR_W-2:0] incr_i,
   input  logic [vread_pkg::BUF_ADDR_W-2:0] shift_i,
   input  logic [vread_pkg::BUF_ADDR_W-2:0] iter_i,
   input  logic [vread_pkg::PERIOD_W-1:0]   per_i,
   input  logic [vread_pkg::DELAY_W-1:0]    delay_i,
   output logic                             valid_o,
   output logic [vread_pkg::BUF_ADDR_W-2:0] addr_o,
   output logic                             done_o
);
   import vread_pkg::*;

   typedef enum logic [1:0] {IDLE, WAIT, ISSUE} phase_t;

   phase_t                phase;
   logic [DELAY_W-1:0]    dly_cnt;
   logic [PERIOD_W-1:0]   inner_cnt;
   logic [BUF_ADDR_W-2:0] outer_cnt;
   logic [BUF_ADDR_W-2:0] base;
   logic [BUF_ADDR_W-2:0] addr;
   logic [BUF_ADDR_W-2:0] next_base;
   logic                  empty;
   logic                  inner_wrap;
   logic                  last_addr;

   // zero per or iter means nothing to issue
   assign empty      = (per_i == '0) || (iter_i == '0);
   assign inner_wrap = (inner_cnt == per_i - 1'b1);
   assign last_addr  = inner_wrap && (outer_cnt == iter_i - 1'b1);
   assign next_base  = base + shift_i;

   assign valid_o = (phase == ISSUE) && !empty;
   assign addr_o  = addr;
   assign done_o  = (phase == IDLE);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phase     <= IDLE;
         dly_cnt   <= '0;
         inner_cnt <= '0;
         outer_cnt <= '0;
         base      <= '0;
         addr      <= '0;
      end else if (run_i) begin
         phase     <= (delay_i == '0) ? ISSUE : WAIT;
         dly_cnt   <= delay_i;
         inner_cnt <= '0;
         outer_cnt <= '0;
         base      <= start_i;
         addr      <= start_i;
      end else begin
         case (phase)
            WAIT: begin
               dly_cnt <= dly_cnt - 1'b1;
               if (dly_cnt == DELAY_W'(1)) phase <= ISSUE;
            end
            ISSUE: begin
               if (empty || last_addr) begin
                  phase <= IDLE;
               end else if (inner_wrap) begin
                  // next outer step restarts from the shifted base
                  inner_cnt <= '0;
                  outer_cnt <= outer_cnt + 1'b1;
                  base      <= next_base;
                  addr      <= next_base;
               end else begin
                  inner_cnt <= inner_cnt + 1'b1;
                  addr      <= addr + incr_i;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

//--- rtl/vread_pkg.sv
package vread_pkg;

   // array shape
   localparam int LANES      = 4;
   localparam int DATA_W     = 32;
   localparam int EXT_ADDR_W = 32;
   // top bit of the buffer address picks the ping-pong half
   localparam int BUF_ADDR_W = 8;
   // burst length field holds words minus one
   localparam int LEN_W      = 8;
   localparam int PERIOD_W   = 6;
   localparam int DELAY_W    = 4;

   typedef struct packed {
      logic                  enabled;
      logic                  ping_pong;
      logic [EXT_ADDR_W-1:0] ext_addr;
      logic [LEN_W-1:0]      len;
      logic [BUF_ADDR_W-2:0] start;
      logic [PERIOD_W-1:0]   per;
      logic [BUF_ADDR_W-2:0] incr;
      logic [BUF_ADDR_W-2:0] iter;
      logic [BUF_ADDR_W-2:0] shift;
      logic [DELAY_W-1:0]    delay;
   } lane_cfg_t;

   // databus request, held until the beat with last
   typedef struct packed {
      logic                  valid;
      logic [EXT_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
   } db_req_t;

   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
      logic              last;
   } db_rsp_t;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] data;
   } lane_out_t;

   typedef struct packed {
      logic [LANES-1:0]             valid;
      logic [LANES-1:0][DATA_W-1:0] data;
   } gather_out_t;

endpackage
